// ==== dv/gpuCircle_properties.sv ====
`timescale 1ns/1ps

module gpuCircle_properties
  import gpuPkg::*;
(
  input logic                  clk,
  input logic                  n_rst,
  input logic                  busy_o,
  input logic                  done_o,
  input logic                  fbWrite_o,
  input fbAddrT                fbAddr_o,
  input logic                  pixPush,
  input logic [FIFO_CNT_W-1:0] fifoCount
);

  busyDoneExclusive: assert property (@(posedge clk) disable iff (!n_rst)
    !(busy_o && done_o))
    else $error("busy_o and done_o are high in the same cycle");

  addrOnScreen: assert property (@(posedge clk) disable iff (!n_rst)
    fbWrite_o |-> (fbAddr_o < SCREEN_W * SCREEN_H))
    else $error("fbAddr_o is outside the framebuffer during a write");

  // The early full flag must keep the last slot for the registered pixel
  noPushWhenFull: assert property (@(posedge clk) disable iff (!n_rst)
    !(pixPush && fifoCount == FIFO_CNT_W'(FIFO_DEPTH)))
    else $error("Pixel pushed into a FIFO that holds FIFO_DEPTH entries");

  quietInReset: assert property (@(posedge clk) !n_rst |-> !fbWrite_o)
    else $error("fbWrite_o is high during reset");

endmodule

bind gpuCircleTop gpuCircle_properties props_i (
  .clk       (clk),
  .n_rst     (n_rst),
  .busy_o    (busy_o),
  .done_o    (done_o),
  .fbWrite_o (fbWrite_o),
  .fbAddr_o  (fbAddr_o),
  .pixPush   (pixPush),
  .fifoCount (fifo_i.count)
);

// ==== dv/circleModel.svh ====
// Octant table as separate x and y mappings of (tx, ty) around the centre
function automatic void mapPoint(input int oct, input int tx, input int ty,
                                 input int xc, input int yc,
                                 output int px, output int py);
  case (oct)
    0, 7: px = xc + ty;
    1, 6: px = xc + tx;
    2, 5: px = xc - tx;
    default: px = xc - ty;
  endcase
  case (oct)
    0, 3: py = yc + tx;
    1, 2: py = yc + ty;
    4, 7: py = yc - tx;
    default: py = yc - ty;
  endcase
endfunction

task automatic buildExpected(input circleCmdT cmd);
  int xc;
  int yc;
  int tx;
  int ty;
  int d;
  int px;
  int py;
  xc = int'(cmd.xc);
  yc = int'(cmd.yc);
  for (int oct = 0; oct < 8; oct++)
  begin
    tx = 0;
    ty = int'(cmd.radius);
    d = 1 - ty;
    while (tx <= ty)
    begin
      mapPoint(oct, tx, ty, xc, yc, px, py);
      // Off-screen points are clipped by the writer
      if (px >= 0 && px < SCREEN_W && py >= 0 && py < SCREEN_H)
      begin
        expAddr.push_back(fbAddrT'(py * SCREEN_W + px));
        expColor.push_back(cmd.color);
      end
      if (d < 0)
        d = d + 2 * tx + 3;
      else
      begin
        d = d + 2 * tx - 2 * ty + 5;
        ty = ty - 1;
      end
      tx = tx + 1;
    end
  end
endtask

// ==== dv/tbGpuCircle.sv ====
`timescale 1ns/1ps

module tbGpuCircle
  import gpuPkg::*;
();

  localparam int DONE_TIMEOUT = 6000;
  localparam int DRAIN_TIMEOUT = 2000;
  localparam int NUM_CIRCLES = 50;

  logic clk;
  logic n_rst;
  logic start_i;
  circleCmdT cmd_i;
  logic fbStall_i;
  logic busy_o;
  logic done_o;
  logic fbWrite_o;
  fbAddrT fbAddr_o;
  colorT fbColor_o;

  int seed;
  fbAddrT expAddr[$];
  colorT expColor[$];
  int writeCount;
  int doneCount;
  logic stallOn;
  logic prevStall;

  `include "circleModel.svh"

  gpuCircleTop dut_i (
    .clk       (clk),
    .n_rst     (n_rst),
    .start_i   (start_i),
    .cmd_i     (cmd_i),
    .fbStall_i (fbStall_i),
    .busy_o    (busy_o),
    .done_o    (done_o),
    .fbWrite_o (fbWrite_o),
    .fbAddr_o  (fbAddr_o),
    .fbColor_o (fbColor_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stopOnError(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic checkAddr(input string name, input fbAddrT got, input fbAddrT exp);
    if (got !== exp)
      stopOnError($sformatf("Fail %s: got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic checkColor(input string name, input colorT got, input colorT exp);
    if (got !== exp)
      stopOnError($sformatf("Fail %s: got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic checkCount(input string name, input int got, input int exp);
    if (got != exp)
      stopOnError($sformatf("Fail %s: got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic checkLevel(input string name, input logic got, input logic exp);
    if (got !== exp)
      stopOnError($sformatf("Fail %s: got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  function automatic int randRange(input int lo, input int hi);
    return lo + (($random(seed) & 32'h7fffffff) % (hi - lo + 1));
  endfunction

  // Advance one clock and drive the new stall level just after the edge
  task automatic nextCycle();
    @(posedge clk);
    #1;
    fbStall_i = stallOn && (randRange(0, 9) < 3);
  endtask

  function automatic circleCmdT makeCommand(input int idx);
    circleCmdT c;
    case (idx)
      0: c.xc = randRange(40, 119);
      1: c.xc = randRange(0, 159);
      2: c.xc = randRange(-20, 10);
      default: c.xc = randRange(-40, 199);
    endcase
    case (idx)
      0: c.yc = randRange(40, 79);
      1: c.yc = randRange(0, 119);
      2: c.yc = randRange(100, 140);
      default: c.yc = randRange(-40, 159);
    endcase
    c.radius = (idx == 1) ? radiusT'(0) : radiusT'(randRange(0, 40));
    if (idx == 2)
      c.radius = radiusT'(randRange(10, 40));
    c.color = colorT'($random(seed));
    return c;
  endfunction

  // The write and done monitor samples mid-cycle where outputs are stable
  always @(negedge clk)
  begin
    if (n_rst)
    begin
      if (fbWrite_o)
      begin
        if (prevStall)
          stopOnError("A framebuffer write followed a stalled cycle");
        else if (expAddr.size() == 0)
          stopOnError("A framebuffer write appeared with none expected");
        else
        begin
          checkAddr("fbAddr_o", fbAddr_o, expAddr.pop_front());
          checkColor("fbColor_o", fbColor_o, expColor.pop_front());
          writeCount++;
        end
      end
      if (done_o)
        doneCount++;
    end
    prevStall = fbStall_i;
  end

  task automatic runCircle(input circleCmdT cmd, input logic startWhileBusy);
    int cycles;
    int expLen;
    buildExpected(cmd);
    expLen = expAddr.size();
    writeCount = 0;
    doneCount = 0;
    cmd_i = cmd;
    start_i = 1'b1;
    nextCycle();
    start_i = 1'b0;
    checkLevel("busy_o", busy_o, 1'b1);
    if (startWhileBusy)
    begin
      // A second command during busy must leave the write stream untouched
      cmd_i = makeCommand(3);
      start_i = 1'b1;
      nextCycle();
      start_i = 1'b0;
    end
    cycles = 0;
    while (doneCount == 0)
    begin
      if (cycles >= DONE_TIMEOUT)
        stopOnError("Timed out waiting for done_o");
      nextCycle();
      cycles++;
    end
    cycles = 0;
    while (!dut_i.fifoEmpty || fbWrite_o)
    begin
      if (cycles >= DRAIN_TIMEOUT)
        stopOnError("Timed out waiting for the last framebuffer write");
      nextCycle();
      cycles++;
    end
    checkCount("write count", writeCount, expLen);
    checkCount("done pulses", doneCount, 1);
    checkLevel("busy_o", busy_o, 1'b0);
  endtask

  initial
  begin
    seed = 59546;
    n_rst = 1'b0;
    start_i = 1'b0;
    cmd_i = '0;
    fbStall_i = 1'b0;
    stallOn = 1'b0;
    prevStall = 1'b0;
    writeCount = 0;
    doneCount = 0;
    repeat (10) @(posedge clk);
    #1;
    n_rst = 1'b1;
    nextCycle();
    checkLevel("busy_o", busy_o, 1'b0);
    checkLevel("done_o", done_o, 1'b0);
    checkLevel("fbWrite_o", fbWrite_o, 1'b0);
    for (int i = 0; i < NUM_CIRCLES; i++)
    begin
      stallOn = (i >= 3);
      runCircle(makeCommand(i), (i % 4) == 3);
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+dv
verilog/gpuPkg.sv
verilog/octantDraw.sv
verilog/circleDraw.sv
verilog/pixelFifo.sv
verilog/pixelWriter.sv
verilog/gpuCircleTop.sv
dv/gpuCircle_properties.sv
dv/tbGpuCircle.sv

// ==== verilog/circleDraw.sv ====
`timescale 1ns/1ps

module circleDraw
  import gpuPkg::*;
(
  input  logic      clk,
  input  logic      n_rst,
  input  logic      start_i,
  input  circleCmdT cmd_i,
  input  logic      fifoFull_i,
  output logic      pixPush_o,
  output pixelT     pix_o,
  output logic      busy_o,
  output logic      done_o
);

  circleCmdT cmdQ;
  octantT octIdx;
  logic octStart;
  logic octDone;
  logic accept;

  assign accept = start_i && !busy_o;

  // Command stays put for all eight passes
  always_ff @(posedge clk)
  begin
    if (accept)
      cmdQ <= cmd_i;
  end

  always_ff @(posedge clk or negedge n_rst)
  begin
    if (!n_rst)
    begin
      busy_o <= 1'b0;
      done_o <= 1'b0;
      octStart <= 1'b0;
      octIdx <= '0;
    end
    else
    begin
      done_o <= 1'b0;
      octStart <= 1'b0;
      if (accept)
      begin
        busy_o <= 1'b1;
        octIdx <= '0;
        octStart <= 1'b1;
      end
      else if (busy_o && octDone)
      begin
        if (octIdx == LAST_OCTANT)
        begin
          busy_o <= 1'b0;
          done_o <= 1'b1;
        end
        else
        begin
          octIdx <= octIdx + 1'b1;
          octStart <= 1'b1;
        end
      end
    end
  end

  // A full FIFO simply freezes the drawer
  octantDraw drawer_i (
    .clk        (clk),
    .n_rst      (n_rst),
    .start_i    (octStart),
    .hold_i     (fifoFull_i),
    .oct_i      (octIdx),
    .xc_i       (cmdQ.xc),
    .yc_i       (cmdQ.yc),
    .radius_i   (cmdQ.radius),
    .color_i    (cmdQ.color),
    .pix_o      (pix_o),
    .pixValid_o (pixPush_o),
    .done_o     (octDone)
  );

endmodule

// ==== verilog/gpuCircleTop.sv ====
`timescale 1ns/1ps

module gpuCircleTop
  import gpuPkg::*;
(
  input  logic      clk,
  input  logic      n_rst,
  input  logic      start_i,
  input  circleCmdT cmd_i,
  input  logic      fbStall_i,
  output logic      busy_o,
  output logic      done_o,
  output logic      fbWrite_o,
  output fbAddrT    fbAddr_o,
  output colorT     fbColor_o
);

  logic pixPush;
  pixelT pixIn;
  pixelT pixHead;
  logic fifoFull;
  logic fifoEmpty;
  logic pixPop;

  circleDraw circle_i (
    .clk        (clk),
    .n_rst      (n_rst),
    .start_i    (start_i),
    .cmd_i      (cmd_i),
    .fifoFull_i (fifoFull),
    .pixPush_o  (pixPush),
    .pix_o      (pixIn),
    .busy_o     (busy_o),
    .done_o     (done_o)
  );

  pixelFifo fifo_i (
    .clk        (clk),
    .n_rst      (n_rst),
    .push_i     (pixPush),
    .pushData_i (pixIn),
    .pop_i      (pixPop),
    .popData_o  (pixHead),
    .full_o     (fifoFull),
    .empty_o    (fifoEmpty)
  );

  pixelWriter writer_i (
    .clk         (clk),
    .n_rst       (n_rst),
    .fifoEmpty_i (fifoEmpty),
    .pixel_i     (pixHead),
    .fbStall_i   (fbStall_i),
    .pop_o       (pixPop),
    .fbWrite_o   (fbWrite_o),
    .fbAddr_o    (fbAddr_o),
    .fbColor_o   (fbColor_o)
  );

endmodule

// ==== verilog/gpuPkg.sv ====
package gpuPkg;

  // Screen geometry
  localparam int SCREEN_W = 160;
  localparam int SCREEN_H = 120;

  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  localparam int COORD_W = 10;
  localparam int RADIUS_W = 7;
  localparam int COLOR_W = 12;
  localparam int FB_ADDR_W = 15;
  localparam int OCT_W = 3;

  // The midpoint decision value needs a few bits more than a coordinate
  localparam int DECISION_W = COORD_W + 2;

  typedef logic signed [COORD_W-1:0] coordT;
  typedef logic [RADIUS_W-1:0] radiusT;
  typedef logic [COLOR_W-1:0] colorT;
  typedef logic [FB_ADDR_W-1:0] fbAddrT;
  typedef logic [OCT_W-1:0] octantT;

  localparam octantT LAST_OCTANT = 3'd7;

  typedef struct packed {
    coordT x;
    coordT y;
    colorT color;
  } pixelT;

  typedef struct packed {
    coordT xc;
    coordT yc;
    radiusT radius;
    colorT color;
  } circleCmdT;

  typedef enum logic {
    IDLE,
    RUN
  } drawStateT;

endpackage

// ==== verilog/octantDraw.sv ====
`timescale 1ns/1ps

module octantDraw
  import gpuPkg::*;
(
  input  logic   clk,
  input  logic   n_rst,
  input  logic   start_i,
  input  logic   hold_i,
  input  octantT oct_i,
  input  coordT  xc_i,
  input  coordT  yc_i,
  input  radiusT radius_i,
  input  colorT  color_i,
  output pixelT  pix_o,
  output logic   pixValid_o,
  output logic   done_o
);

  drawStateT state;
  logic startQ;
  logic startEdge;
  logic stepEn;
  logic finished;

  octantT octQ;
  coordT xcQ;
  coordT ycQ;
  colorT colorQ;
  coordT tx;
  coordT ty;
  logic signed [DECISION_W-1:0] decision;

  logic swapXY;
  logic negX;
  logic negY;
  coordT offX;
  coordT offY;
  coordT mapX;
  coordT mapY;

  // Only the first cycle of a start level counts
  assign startEdge = start_i & ~startQ;
  assign stepEn = (state == RUN) && !hold_i;
  assign finished = tx > ty;

  // Octants 0, 3, 4 and 7 swap the axes while 2 to 5 mirror x and 4 to 7 mirror y
  always_comb
  begin
    swapXY = (octQ == 3'd0) || (octQ == 3'd3) || (octQ == 3'd4) || (octQ == 3'd7);
    negX = (octQ >= 3'd2) && (octQ <= 3'd5);
    negY = octQ[2];
    offX = swapXY ? ty : tx;
    offY = swapXY ? tx : ty;
    mapX = negX ? xcQ - offX : xcQ + offX;
    mapY = negY ? ycQ - offY : ycQ + offY;
  end

  always_ff @(posedge clk or negedge n_rst)
  begin
    if (!n_rst)
    begin
      state <= IDLE;
      startQ <= 1'b0;
      pixValid_o <= 1'b0;
      done_o <= 1'b0;
    end
    else
    begin
      startQ <= start_i;
      pixValid_o <= 1'b0;
      done_o <= 1'b0;
      if (state == IDLE)
      begin
        if (startEdge)
          state <= RUN;
      end
      else if (stepEn)
      begin
        if (finished)
        begin
          done_o <= 1'b1;
          state <= IDLE;
        end
        else
          pixValid_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == IDLE && startEdge)
    begin
      octQ <= oct_i;
      xcQ <= xc_i;
      ycQ <= yc_i;
      colorQ <= color_i;
      tx <= '0;
      ty <= coordT'(radius_i);
      decision <= 1 - DECISION_W'(coordT'(radius_i));
    end
    else if (stepEn && !finished)
    begin
      pix_o <= '{x: mapX, y: mapY, color: colorQ};
      if (decision < 0)
        decision <= decision + 2 * DECISION_W'(tx) + 3;
      else
      begin
        decision <= decision + 2 * DECISION_W'(tx) - 2 * DECISION_W'(ty) + 5;
        ty <= ty - 1;
      end
      tx <= tx + 1;
    end
  end

endmodule

// ==== verilog/pixelFifo.sv ====
`timescale 1ns/1ps

module pixelFifo
  import gpuPkg::*;
(
  input  logic  clk,
  input  logic  n_rst,
  input  logic  push_i,
  input  pixelT pushData_i,
  input  logic  pop_i,
  output pixelT popData_o,
  output logic  full_o,
  output logic  empty_o
);

  pixelT mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wrPtr;
  logic [FIFO_PTR_W-1:0] rdPtr;
  logic [FIFO_CNT_W-1:0] count;
  logic doPush;
  logic doPop;

  function automatic logic [FIFO_PTR_W-1:0] nextPtr(input logic [FIFO_PTR_W-1:0] ptr);
    if (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign doPush = push_i && (count != FIFO_CNT_W'(FIFO_DEPTH));
  assign doPop = pop_i && !empty_o;

  // Early full leaves a slot for the pixel already in the drawer's output register
  assign full_o = count >= FIFO_CNT_W'(FIFO_DEPTH - 1);
  assign empty_o = count == '0;
  assign popData_o = mem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (doPush)
      mem[wrPtr] <= pushData_i;
  end

  always_ff @(posedge clk or negedge n_rst)
  begin
    if (!n_rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doPush)
        wrPtr <= nextPtr(wrPtr);
      if (doPop)
        rdPtr <= nextPtr(rdPtr);
      if (doPush && !doPop)
        count <= count + 1'b1;
      else if (doPop && !doPush)
        count <= count - 1'b1;
    end
  end

endmodule

// ==== verilog/pixelWriter.sv ====
`timescale 1ns/1ps

module pixelWriter
  import gpuPkg::*;
(
  input  logic   clk,
  input  logic   n_rst,
  input  logic   fifoEmpty_i,
  input  pixelT  pixel_i,
  input  logic   fbStall_i,
  output logic   pop_o,
  output logic   fbWrite_o,
  output fbAddrT fbAddr_o,
  output colorT  fbColor_o
);

  logic inBounds;
  logic [COORD_W-1:0] xU;
  logic [COORD_W-1:0] yU;
  fbAddrT linAddr;

  assign pop_o = !fifoEmpty_i && !fbStall_i;

  assign inBounds = (pixel_i.x >= 0) && (pixel_i.x < SCREEN_W) &&
                    (pixel_i.y >= 0) && (pixel_i.y < SCREEN_H);

  // Only meaningful once the bounds test has passed
  assign xU = pixel_i.x;
  assign yU = pixel_i.y;
  assign linAddr = fbAddrT'(yU * SCREEN_W + xU);

  always_ff @(posedge clk or negedge n_rst)
  begin
    if (!n_rst)
      fbWrite_o <= 1'b0;
    else
      fbWrite_o <= pop_o && inBounds;
  end

  always_ff @(posedge clk)
  begin
    if (pop_o)
    begin
      fbAddr_o <= linAddr;
      fbColor_o <= pixel_i.color;
    end
  end

endmodule
